//--- verilog/radio_regs_pkg.sv
// Radio register map
package radio_regs_pkg;

  // Settings bus data width
  localparam int SET_DATA_W = 32;
  // Readback word width
  localparam int RB_DATA_W = 64;
  // Full VITA time width
  localparam int TIME_W = 64;
  // Packet length and burst sample count width
  localparam int RX_MAXLEN_W = 16;

  // Settings bus addresses
  typedef enum logic [7:0] {
    // Bit 0 loops TX samples back into RX
    SR_LOOPBACK   = 8'd0,
    // Free scratch word, read back on RB_TEST
    SR_TEST       = 8'd1,
    // DAC word while TX is not playing
    SR_CODEC_IDLE = 8'd2,
    // Samples per RX packet
    SR_RX_MAXLEN  = 8'd3,
    // Starts an RX burst, low bits give the sample count
    SR_RX_COMMAND = 8'd4,
    // Channel stop, bit 1 also ends a TX burst
    SR_RX_HALT    = 8'd5
  } sr_addr_e;

  // Readback addresses
  typedef enum logic [7:0] {
    RB_VITA_TIME = 8'd0,
    // ADC sample over test word
    RB_TEST      = 8'd1,
    // DAC sample over ADC sample
    RB_TXRX      = 8'd2,
    RB_RADIO_NUM = 8'd3
  } rb_addr_e;

  // TX burst player states
  typedef enum logic [1:0] {
    TX_IDLE,
    TX_RUN,
    TX_REPORT
  } tx_state_e;

  // RX burst capture states
  typedef enum logic [1:0] {
    RX_IDLE,
    RX_RUN,
    RX_REPORT
  } rx_state_e;

endpackage

//--- verilog/radio_stream_pkg.sv
// Radio stream types
package radio_stream_pkg;

  // One I or Q component
  localparam int COMP_W = 16;
  // Low part of VITA time carried in reports
  localparam int RESP_TIME_W = 32;

  // Report source flags
  localparam logic SRC_TX = 1'b0;
  localparam logic SRC_RX = 1'b1;

  // Complex sample, I in the upper half
  typedef struct packed {
    logic [COMP_W-1:0] i;
    logic [COMP_W-1:0] q;
  } sample_t;

  // TX stream beat
  typedef struct packed {
    sample_t data;
    // Last sample of a burst
    logic    eob;
  } tx_beat_t;

  // RX stream beat
  typedef struct packed {
    sample_t data;
    // Last sample of a packet
    logic    last;
  } rx_beat_t;

  // Report codes
  typedef enum logic [1:0] {
    RESP_ACK       = 2'd0,
    RESP_UNDERFLOW = 2'd1,
    RESP_OVERFLOW  = 2'd2
  } resp_code_e;

  // Report word, 35 bits
  typedef struct packed {
    resp_code_e             code;
    logic                   src;
    logic [RESP_TIME_W-1:0] timestamp;
  } resp_t;

endpackage

//--- verilog/radio_settings.sv
// Radio settings and readback
`timescale 1ns/1ps

module radio_settings
  import radio_regs_pkg::*, radio_stream_pkg::*;
#(
  parameter int RADIO_NUM = 0
) (
  input  logic                  clk,
  input  logic                  reset,
  // Settings bus
  input  logic                  i_set_stb,
  input  sr_addr_e              i_set_addr,
  input  logic [SET_DATA_W-1:0] i_set_data,
  // Readback port
  input  rb_addr_e              i_rb_addr,
  input  logic [TIME_W-1:0]     i_vita_time,
  input  sample_t               i_rx,
  input  sample_t               i_tx,
  output logic                  o_rb_stb,
  output logic [RB_DATA_W-1:0]  o_rb_data,
  // Register outputs
  output logic                  o_loopback,
  output sample_t               o_idle
);

  logic [SET_DATA_W-1:0] test_reg;

  // Register writes land one cycle after the strobe
  always_ff @(posedge clk) begin
    if (reset) begin
      o_loopback <= 1'b0;
      test_reg   <= '0;
      o_idle     <= '0;
    end else if (i_set_stb) begin
      case (i_set_addr)
        SR_LOOPBACK:   o_loopback <= i_set_data[0];
        SR_TEST:       test_reg   <= i_set_data;
        SR_CODEC_IDLE: o_idle     <= i_set_data;
        // Other addresses belong to the controls
        default:       ;
      endcase
    end
  end

  // Readback valid every cycle once out of reset
  always_ff @(posedge clk) begin
    if (reset) begin
      o_rb_stb <= 1'b0;
    end else begin
      o_rb_stb <= 1'b1;
    end
  end

  // Registered readback mux
  always_ff @(posedge clk) begin
    case (i_rb_addr)
      RB_VITA_TIME: o_rb_data <= i_vita_time;
      RB_TEST:      o_rb_data <= {i_rx, test_reg};
      RB_TXRX:      o_rb_data <= {i_tx, i_rx};
      RB_RADIO_NUM: o_rb_data <= {32'd0, 32'(RADIO_NUM)};
      // Unknown addresses read zero
      default:      o_rb_data <= '0;
    endcase
  end

  // Test word written on one cycle reads back two cycles later
  a_rb_test: assert property (
    @(posedge clk) disable iff (reset)
    i_rb_addr == RB_TEST && $past(i_set_stb && i_set_addr == SR_TEST)
      |=> o_rb_stb && o_rb_data[SET_DATA_W-1:0] == $past(i_set_data, 2)
  ) else $error("test word readback not two cycles after its write");

endmodule

//--- verilog/radio_tx_control.sv
// TX burst player
`timescale 1ns/1ps

module radio_tx_control
  import radio_regs_pkg::*, radio_stream_pkg::*;
(
  input  logic                  clk,
  input  logic                  reset,
  // Settings bus
  input  logic                  i_set_stb,
  input  sr_addr_e              i_set_addr,
  input  logic [SET_DATA_W-1:0] i_set_data,
  // Sample stream in
  input  tx_beat_t              i_tx,
  input  logic                  i_tx_valid,
  output logic                  o_tx_ready,
  // DAC side
  input  logic                  i_tx_stb,
  input  sample_t               i_idle,
  input  logic [TIME_W-1:0]     i_vita_time,
  output sample_t               o_sample,
  // Report stream
  output resp_t                 o_resp,
  output logic                  o_resp_valid,
  input  logic                  i_resp_ready
);

  tx_state_e state;
  sample_t   sample_reg;
  // Holds while sample_reg is the word the DAC plays
  logic      playing;
  logic      pop;
  logic      starve;
  logic      stop;
  logic      done;

  // Stop with bit 1 set cuts the burst short
  assign stop = i_set_stb && (i_set_addr == SR_RX_HALT) && i_set_data[1];

  // One beat per DAC strobe, only while running
  assign o_tx_ready = (state == TX_RUN) && i_tx_stb;
  assign pop        = o_tx_ready && i_tx_valid;
  // Strobe with an empty stream
  assign starve     = o_tx_ready && !i_tx_valid;
  // End of burst, dry stream or stop
  assign done       = (state == TX_RUN) && ((pop && i_tx.eob) || starve || stop);

  always_ff @(posedge clk) begin
    if (reset) begin
      state   <= TX_IDLE;
      playing <= 1'b0;
    end else begin
      // A strobe with nothing popped drops back to the idle word
      if (pop) begin
        playing <= 1'b1;
      end else if (i_tx_stb) begin
        playing <= 1'b0;
      end
      case (state)
        TX_IDLE: begin
          if (i_tx_valid) begin
            state <= TX_RUN;
          end
        end
        TX_RUN: begin
          if (done) begin
            state <= TX_REPORT;
          end
        end
        // No samples taken until the report leaves
        TX_REPORT: begin
          if (i_resp_ready) begin
            state <= TX_IDLE;
          end
        end
        default: state <= TX_IDLE;
      endcase
    end
  end

  // Sample and report payload
  always_ff @(posedge clk) begin
    if (pop) begin
      sample_reg <= i_tx.data;
    end
    if (done) begin
      o_resp.code      <= starve ? RESP_UNDERFLOW : RESP_ACK;
      o_resp.src       <= SRC_TX;
      o_resp.timestamp <= i_vita_time[RESP_TIME_W-1:0];
    end
  end

  assign o_resp_valid = (state == TX_REPORT);
  // Idle word outside a burst
  assign o_sample     = playing ? sample_reg : i_idle;

  // A beat leaves the stream only on a strobe and plays on the next cycle
  a_tx_pop: assert property (
    @(posedge clk) disable iff (reset)
    o_tx_ready && i_tx_valid |-> i_tx_stb ##1 o_sample == $past(i_tx.data)
  ) else $error("popped TX beat not on the DAC one cycle later");

endmodule

//--- verilog/radio_rx_control.sv
// RX burst capture and packetizer
`timescale 1ns/1ps

module radio_rx_control
  import radio_regs_pkg::*, radio_stream_pkg::*;
(
  input  logic                  clk,
  input  logic                  reset,
  // Settings bus
  input  logic                  i_set_stb,
  input  sr_addr_e              i_set_addr,
  input  logic [SET_DATA_W-1:0] i_set_data,
  // ADC side
  input  sample_t               i_sample,
  input  logic                  i_sample_stb,
  input  logic [TIME_W-1:0]     i_vita_time,
  // Packet stream out
  output rx_beat_t              o_rx,
  output logic                  o_rx_valid,
  input  logic                  i_rx_ready,
  // Report stream
  output resp_t                 o_resp,
  output logic                  o_resp_valid,
  input  logic                  i_resp_ready
);

  rx_state_e              state;
  logic [RX_MAXLEN_W-1:0] maxlen;
  // Samples left in the burst
  logic [RX_MAXLEN_W-1:0] remain;
  // Position inside the current packet
  logic [RX_MAXLEN_W-1:0] pkt_cnt;
  rx_beat_t               rx_buf;
  logic                   buf_valid;
  logic                   cmd;
  logic                   halt;
  logic                   busy;
  logic                   load;
  logic                   overflow;
  logic                   pkt_last;
  logic                   final_smp;

  assign cmd  = i_set_stb && (i_set_addr == SR_RX_COMMAND);
  assign halt = i_set_stb && (i_set_addr == SR_RX_HALT);

  // Buffer counts as free when it drains this cycle
  assign busy      = buf_valid && !i_rx_ready;
  assign load      = (state == RX_RUN) && i_sample_stb && !busy && !halt;
  assign overflow  = (state == RX_RUN) && i_sample_stb && busy && !halt;
  // Zero maxlen wraps to a full 64K packet
  assign pkt_last  = (pkt_cnt == maxlen - 1'b1);
  assign final_smp = (remain == 1);

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= RX_IDLE;
      maxlen    <= '0;
      remain    <= '0;
      pkt_cnt   <= '0;
      buf_valid <= 1'b0;
    end else begin
      if (i_set_stb && i_set_addr == SR_RX_MAXLEN) begin
        maxlen <= i_set_data[RX_MAXLEN_W-1:0];
      end
      if (load) begin
        buf_valid <= 1'b1;
      end else if (i_rx_ready) begin
        buf_valid <= 1'b0;
      end
      case (state)
        // Commands count only here, a zero count is ignored
        RX_IDLE: begin
          if (cmd && i_set_data[RX_MAXLEN_W-1:0] != '0) begin
            state   <= RX_RUN;
            remain  <= i_set_data[RX_MAXLEN_W-1:0];
            pkt_cnt <= '0;
          end
        end
        RX_RUN: begin
          if (load) begin
            remain  <= remain - 1'b1;
            pkt_cnt <= pkt_last ? '0 : pkt_cnt + 1'b1;
          end
          if (halt || (load && final_smp)) begin
            state <= RX_IDLE;
          end else if (overflow) begin
            // Rest of the burst is dropped
            state <= RX_REPORT;
          end
        end
        RX_REPORT: begin
          if (i_resp_ready) begin
            state <= RX_IDLE;
          end
        end
        default: state <= RX_IDLE;
      endcase
    end
  end

  // One-entry output buffer and report payload
  always_ff @(posedge clk) begin
    if (load) begin
      rx_buf <= '{data: i_sample, last: pkt_last || final_smp};
    end
    if (overflow) begin
      o_resp.code      <= RESP_OVERFLOW;
      o_resp.src       <= SRC_RX;
      o_resp.timestamp <= i_vita_time[RESP_TIME_W-1:0];
    end
  end

  assign o_rx         = rx_buf;
  assign o_rx_valid   = buf_valid;
  assign o_resp_valid = (state == RX_REPORT);

  // Stalled beat stays put until taken
  a_rx_hold: assert property (
    @(posedge clk) disable iff (reset)
    o_rx_valid && !i_rx_ready |=> o_rx_valid && $stable(o_rx)
  ) else $error("RX beat changed while stalled");

endmodule

//--- verilog/radio_resp_mux.sv
// TX and RX report combiner
`timescale 1ns/1ps

module radio_resp_mux
  import radio_stream_pkg::*;
(
  input  logic  clk,
  input  logic  reset,
  // TX reports
  input  resp_t i_tx_resp,
  input  logic  i_tx_valid,
  output logic  o_tx_ready,
  // RX reports
  input  resp_t i_rx_resp,
  input  logic  i_rx_valid,
  output logic  o_rx_ready,
  // Combined reports
  output resp_t o_resp,
  output logic  o_resp_valid,
  input  logic  i_resp_ready
);

  // Set when RX wins a tie
  logic prio;
  logic load;
  logic grant_tx;
  logic grant_rx;

  // Output register takes a new word when empty or draining
  assign load     = !o_resp_valid || i_resp_ready;
  assign grant_tx = i_tx_valid && (!i_rx_valid || !prio);
  assign grant_rx = i_rx_valid && !grant_tx;

  assign o_tx_ready = load && grant_tx;
  assign o_rx_ready = load && grant_rx;

  always_ff @(posedge clk) begin
    if (reset) begin
      o_resp_valid <= 1'b0;
      prio         <= 1'b0;
    end else if (load) begin
      o_resp_valid <= grant_tx || grant_rx;
      // Priority passes to the input that lost
      if (grant_tx || grant_rx) begin
        prio <= grant_tx;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (o_tx_ready) begin
      o_resp <= i_tx_resp;
    end else if (o_rx_ready) begin
      o_resp <= i_rx_resp;
    end
  end

endmodule

//--- verilog/radio_core.sv
// Radio channel core
`timescale 1ns/1ps

module radio_core
  import radio_regs_pkg::*, radio_stream_pkg::*;
#(
  parameter int RADIO_NUM = 0
) (
  input  logic                  clk,
  input  logic                  reset,
  // Settings and readback
  input  logic                  i_set_stb,
  input  sr_addr_e              i_set_addr,
  input  logic [SET_DATA_W-1:0] i_set_data,
  input  rb_addr_e              i_rb_addr,
  output logic                  o_rb_stb,
  output logic [RB_DATA_W-1:0]  o_rb_data,
  // Sample streams
  input  tx_beat_t              i_tx,
  input  logic                  i_tx_valid,
  output logic                  o_tx_ready,
  output rx_beat_t              o_rx,
  output logic                  o_rx_valid,
  input  logic                  i_rx_ready,
  // Reports
  output resp_t                 o_resp,
  output logic                  o_resp_valid,
  input  logic                  i_resp_ready,
  // Converters and time
  input  sample_t               i_rx,
  input  logic                  i_rx_stb,
  output sample_t               o_tx,
  input  logic                  i_tx_stb,
  input  logic [TIME_W-1:0]     i_vita_time
);

  logic    loopback;
  sample_t idle_word;
  sample_t rx_sample;
  logic    rx_sample_stb;
  resp_t   tx_resp;
  logic    tx_resp_valid;
  logic    tx_resp_ready;
  resp_t   rx_resp;
  logic    rx_resp_valid;
  logic    rx_resp_ready;

  // Digital loopback, DAC word and strobe replace the ADC
  assign rx_sample     = loopback ? o_tx : i_rx;
  assign rx_sample_stb = loopback ? i_tx_stb : i_rx_stb;

  radio_settings #(.RADIO_NUM(RADIO_NUM)) radio_settings_i (
    .clk(clk), .reset(reset),
    .i_set_stb(i_set_stb), .i_set_addr(i_set_addr), .i_set_data(i_set_data),
    .i_rb_addr(i_rb_addr), .i_vita_time(i_vita_time), .i_rx(i_rx), .i_tx(o_tx),
    .o_rb_stb(o_rb_stb), .o_rb_data(o_rb_data),
    .o_loopback(loopback), .o_idle(idle_word));

  radio_tx_control radio_tx_control_i (
    .clk(clk), .reset(reset),
    .i_set_stb(i_set_stb), .i_set_addr(i_set_addr), .i_set_data(i_set_data),
    .i_tx(i_tx), .i_tx_valid(i_tx_valid), .o_tx_ready(o_tx_ready),
    .i_tx_stb(i_tx_stb), .i_idle(idle_word), .i_vita_time(i_vita_time), .o_sample(o_tx),
    .o_resp(tx_resp), .o_resp_valid(tx_resp_valid), .i_resp_ready(tx_resp_ready));

  radio_rx_control radio_rx_control_i (
    .clk(clk), .reset(reset),
    .i_set_stb(i_set_stb), .i_set_addr(i_set_addr), .i_set_data(i_set_data),
    .i_sample(rx_sample), .i_sample_stb(rx_sample_stb), .i_vita_time(i_vita_time),
    .o_rx(o_rx), .o_rx_valid(o_rx_valid), .i_rx_ready(i_rx_ready),
    .o_resp(rx_resp), .o_resp_valid(rx_resp_valid), .i_resp_ready(rx_resp_ready));

  radio_resp_mux radio_resp_mux_i (
    .clk(clk), .reset(reset),
    .i_tx_resp(tx_resp), .i_tx_valid(tx_resp_valid), .o_tx_ready(tx_resp_ready),
    .i_rx_resp(rx_resp), .i_rx_valid(rx_resp_valid), .o_rx_ready(rx_resp_ready),
    .o_resp(o_resp), .o_resp_valid(o_resp_valid), .i_resp_ready(i_resp_ready));

endmodule

//--- verification/radio_core_checks.sv
// Radio core checker
`timescale 1ns/1ps

module radio_core_checks
  import radio_regs_pkg::*, radio_stream_pkg::*;
#(
  parameter int RADIO_NUM = 0
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  i_set_stb,
  input  sr_addr_e              i_set_addr,
  input  logic [SET_DATA_W-1:0] i_set_data,
  input  rb_addr_e              i_rb_addr,
  input  logic                  o_rb_stb,
  input  logic [RB_DATA_W-1:0]  o_rb_data,
  input  tx_beat_t              i_tx,
  input  logic                  i_tx_valid,
  input  logic                  o_tx_ready,
  input  rx_beat_t              o_rx,
  input  logic                  o_rx_valid,
  input  logic                  i_rx_ready,
  input  resp_t                 o_resp,
  input  logic                  o_resp_valid,
  input  logic                  i_resp_ready,
  input  sample_t               i_rx,
  input  logic                  i_rx_stb,
  input  sample_t               o_tx,
  input  logic                  i_tx_stb,
  input  logic [TIME_W-1:0]     i_vita_time,
  output int                    o_errors,
  output int                    o_pending,
  output int                    o_rx_left
);

  // Predicted registers
  logic                   loop_m;
  logic [SET_DATA_W-1:0]  test_m;
  sample_t                idle_m;
  logic [RX_MAXLEN_W-1:0] maxlen_m;
  // Sample on the DAC while a burst plays
  sample_t                play_m;
  logic                   play_valid_m;
  logic [RB_DATA_W-1:0]   exp_rb;
  sample_t                exp_tx;
  sample_t                rx_in;
  logic                   rx_stb;
  logic                   last_flag;
  // Burst samples still to capture
  int                     rx_left;
  int                     rx_idx;
  int                     found;
  int                     errors = 0;
  rx_beat_t               exp_beat;
  rx_beat_t               rx_q[$];
  resp_t                  resp_q[$];

  assign exp_tx    = play_valid_m ? play_m : idle_m;
  // Loopback takes the DAC word and strobe
  assign rx_in     = loop_m ? exp_tx : i_rx;
  assign rx_stb    = loop_m ? i_tx_stb : i_rx_stb;
  assign o_errors  = errors;

  task automatic report_mismatch(string name, logic [63:0] exp, logic [63:0] got);
    errors++;
    $display("Fail at %0t: %s expected %h, got %h", $time, name, exp, got);
  endtask

  task automatic report_problem(string what);
    errors++;
    $display("Error at %0t: %s", $time, what);
  endtask

  always @(posedge clk) begin
    if (reset) begin
      loop_m       <= 1'b0;
      test_m       <= '0;
      idle_m       <= '0;
      maxlen_m     <= '0;
      play_valid_m <= 1'b0;
      rx_left      = 0;
      rx_q.delete();
      resp_q.delete();
    end else begin
      if (i_set_stb) begin
        case (i_set_addr)
          SR_LOOPBACK:   loop_m   <= i_set_data[0];
          SR_TEST:       test_m   <= i_set_data;
          SR_CODEC_IDLE: idle_m   <= i_set_data;
          SR_RX_MAXLEN:  maxlen_m <= i_set_data[RX_MAXLEN_W-1:0];
          default:       ;
        endcase
      end
      // DAC follows each strobe, idle word when nothing was taken
      if (o_tx_ready && i_tx_valid) begin
        play_m       <= i_tx.data;
        play_valid_m <= 1'b1;
      end else if (i_tx_stb) begin
        play_valid_m <= 1'b0;
      end
      if (o_tx_ready && i_tx_valid && i_tx.eob) begin
        resp_q.push_back('{RESP_ACK, SRC_TX, i_vita_time[RESP_TIME_W-1:0]});
      end
      if (o_tx_ready && !i_tx_valid) begin
        resp_q.push_back('{RESP_UNDERFLOW, SRC_TX, i_vita_time[RESP_TIME_W-1:0]});
      end
      // RX burst, a strobe into a stalled beat is an overflow
      if (i_set_stb && i_set_addr == SR_RX_COMMAND && rx_left == 0) begin
        rx_left = int'(i_set_data[RX_MAXLEN_W-1:0]);
        rx_idx  = 0;
      end else if (rx_stb && rx_left > 0) begin
        if (o_rx_valid && !i_rx_ready) begin
          resp_q.push_back('{RESP_OVERFLOW, SRC_RX, i_vita_time[RESP_TIME_W-1:0]});
          rx_left = 0;
        end else begin
          last_flag = (maxlen_m != 0 && ((rx_idx + 1) % int'(maxlen_m)) == 0) || rx_left == 1;
          rx_q.push_back('{data: rx_in, last: last_flag});
          rx_left--;
          rx_idx++;
        end
      end
      assert (o_tx == exp_tx) else report_mismatch("o_tx", exp_tx, o_tx);
      if (o_rx_valid && i_rx_ready) begin
        if (rx_q.size() == 0) begin
          report_problem("RX beat arrived when none was expected");
        end else begin
          exp_beat = rx_q.pop_front();
          assert (o_rx == exp_beat) else report_mismatch("o_rx", exp_beat, o_rx);
        end
      end
      // Reports may come in either order
      if (o_resp_valid && i_resp_ready) begin
        found = -1;
        for (int k = 0; k < resp_q.size(); k++) begin
          if (found < 0 && resp_q[k] == o_resp) begin
            found = k;
          end
        end
        if (found < 0) begin
          report_problem($sformatf("unexpected report %h", o_resp));
        end else begin
          resp_q.delete(found);
        end
      end
    end
    case (i_rb_addr)
      RB_VITA_TIME: exp_rb <= i_vita_time;
      RB_TEST:      exp_rb <= {i_rx, test_m};
      RB_TXRX:      exp_rb <= {exp_tx, i_rx};
      RB_RADIO_NUM: exp_rb <= 64'(RADIO_NUM);
      default:      exp_rb <= '0;
    endcase
    o_pending <= resp_q.size();
    o_rx_left <= rx_q.size() + rx_left;
  end

  // Every address gets a strobed answer one cycle later
  a_readback: assert property (
    @(posedge clk) disable iff (reset)
    !$past(reset) |-> o_rb_stb && o_rb_data == exp_rb
  ) else report_mismatch("o_rb_data", $sampled(exp_rb), $sampled(o_rb_data));

  // TX beats leave the stream only on a DAC strobe
  a_tx_strobe: assert property (
    @(posedge clk) disable iff (reset) o_tx_ready |-> i_tx_stb
  ) else report_problem("TX beat taken without a DAC strobe");

  a_resp_stall: assert property (
    @(posedge clk) disable iff (reset)
    o_resp_valid && !i_resp_ready |=> o_resp_valid && $stable(o_resp)
  ) else report_problem("report changed or vanished while stalled");

  // Outputs idle right after reset
  a_reset_state: assert property (
    @(posedge clk) reset |=> !o_rb_stb && !o_rx_valid && !o_resp_valid && o_tx == '0
  ) else report_problem("outputs not idle after reset");

endmodule

//--- verification/radio_core_tb.sv
// Radio core testbench
`timescale 1ns/1ps

module radio_core_tb
  import radio_regs_pkg::*, radio_stream_pkg::*;
;

  // Channel number seen on the readback port
  localparam int RADIO_NUM = 3;

  logic                  clk = 1'b0;
  logic                  reset;
  logic                  i_set_stb;
  sr_addr_e              i_set_addr;
  logic [SET_DATA_W-1:0] i_set_data;
  rb_addr_e              i_rb_addr;
  logic                  o_rb_stb;
  logic [RB_DATA_W-1:0]  o_rb_data;
  tx_beat_t              i_tx;
  logic                  i_tx_valid;
  logic                  o_tx_ready;
  rx_beat_t              o_rx;
  logic                  o_rx_valid;
  logic                  i_rx_ready;
  resp_t                 o_resp;
  logic                  o_resp_valid;
  logic                  i_resp_ready;
  sample_t               i_rx = '0;
  logic                  i_rx_stb = 1'b0;
  sample_t               o_tx;
  logic                  i_tx_stb = 1'b0;
  logic [TIME_W-1:0]     i_vita_time = '0;
  integer                seed = 32'h4fd1edf4;
  int                    cyc = 0;
  int                    timeouts = 0;
  int                    check_errors;
  int                    pending;
  int                    rx_left;

  radio_core #(.RADIO_NUM(RADIO_NUM)) radio_core_i (.*);

  radio_core_checks #(.RADIO_NUM(RADIO_NUM)) radio_core_checks_i (
    .*, .o_errors(check_errors), .o_pending(pending), .o_rx_left(rx_left));

  always #50 clk = ~clk;

  // Converter strobes every fourth cycle, time counts cycles
  always @(posedge clk) begin
    #1;
    cyc++;
    i_vita_time = i_vita_time + 1;
    i_tx_stb    = (cyc % 4 == 0);
    i_rx_stb    = (cyc % 4 == 0);
    if (i_rx_stb) begin
      i_rx = {i_vita_time[15:0], ~i_vita_time[15:0]};
    end
  end

  task automatic note_timeout(string what);
    timeouts++;
    $display("Timeout at %0t: %s", $time, what);
  endtask

  task automatic write_reg(sr_addr_e addr, logic [SET_DATA_W-1:0] data);
    @(posedge clk);
    #1;
    i_set_stb  = 1'b1;
    i_set_addr = addr;
    i_set_data = data;
    @(posedge clk);
    #1;
    i_set_stb  = 1'b0;
  endtask

  task automatic send_tx_burst(int n, bit with_eob);
    bit taken;
    for (int k = 0; k < n; k++) begin
      i_tx.data  = $random(seed);
      i_tx.eob   = with_eob && (k == n - 1);
      i_tx_valid = 1'b1;
      taken      = 1'b0;
      for (int t = 0; t < 100 && !taken; t++) begin
        @(posedge clk);
        taken = o_tx_ready;
      end
      if (!taken) begin
        note_timeout("TX beat was never taken");
      end
      #1;
    end
    i_tx_valid = 1'b0;
  endtask

  task automatic wait_first_pop();
    bit seen;
    seen = 1'b0;
    for (int t = 0; t < 100 && !seen; t++) begin
      @(posedge clk);
      seen = o_tx_ready && i_tx_valid;
    end
    if (!seen) begin
      note_timeout("first TX beat was never taken");
    end
  endtask

  task automatic wait_reports(int n);
    bit reached;
    reached = 1'b0;
    for (int t = 0; t < 200 && !reached; t++) begin
      @(posedge clk);
      reached = (pending >= n);
    end
    if (!reached) begin
      note_timeout("reports were never raised");
    end
  endtask

  // All expected beats and reports delivered
  task automatic wait_drained();
    bit empty;
    empty = 1'b0;
    for (int t = 0; t < 400 && !empty; t++) begin
      @(posedge clk);
      empty = (pending == 0) && (rx_left == 0) && !o_resp_valid && !o_rx_valid;
    end
    if (!empty) begin
      note_timeout("expected beats or reports never arrived");
    end
    #1;
  endtask

  initial begin
    reset        = 1'b1;
    i_set_stb    = 1'b0;
    i_set_addr   = SR_LOOPBACK;
    i_set_data   = '0;
    i_rb_addr    = RB_VITA_TIME;
    i_tx         = '0;
    i_tx_valid   = 1'b0;
    i_rx_ready   = 1'b1;
    i_resp_ready = 1'b1;
    repeat (5) @(posedge clk);
    #1;
    reset = 1'b0;

    // Readback of every address, two unknown ones among them
    write_reg(SR_TEST, $random(seed));
    write_reg(SR_CODEC_IDLE, $random(seed));
    for (int a = 0; a < 6; a++) begin
      @(posedge clk);
      #1;
      i_rb_addr = rb_addr_e'((a < 4) ? a : 8'hf0 + a);
      repeat (2) @(posedge clk);
    end

    // Loopback capture of a played burst, packets of three
    write_reg(SR_LOOPBACK, 32'd1);
    write_reg(SR_RX_MAXLEN, 32'd3);
    fork
      send_tx_burst(6, 1'b1);
      begin
        wait_first_pop();
        write_reg(SR_RX_COMMAND, 32'd5);
      end
    join
    wait_drained();

    // Overflow and underflow together with reports stalled
    write_reg(SR_LOOPBACK, 32'd0);
    i_rx_ready   = 1'b0;
    i_resp_ready = 1'b0;
    write_reg(SR_RX_COMMAND, 32'd6);
    send_tx_burst(2, 1'b0);
    wait_reports(2);
    repeat (6) @(posedge clk);
    #1;
    i_rx_ready   = 1'b1;
    i_resp_ready = 1'b1;
    wait_drained();
    repeat (8) @(posedge clk);

    $display("Error counts: %0d check errors, %0d timeouts", check_errors, timeouts);
    if (check_errors == 0 && timeouts == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

//--- list.f
verilog/radio_regs_pkg.sv
verilog/radio_stream_pkg.sv
verilog/radio_settings.sv
verilog/radio_tx_control.sv
verilog/radio_rx_control.sv
verilog/radio_resp_mux.sv
verilog/radio_core.sv
verification/radio_core_checks.sv
verification/radio_core_tb.sv

//--- Makefile
# Verilator simulation of the radio core

LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the radio core testbench"
	@echo "  clean  remove build output and log"

test:
	verilator --binary --timing --assert -Wno-fatal -f list.f \
		--top-module radio_core_tb -o radio_core_sim
	./obj_dir/radio_core_sim | tee $(LOG)
	@if grep -q "Test failures found" $(LOG); then \
		echo "Simulation failed"; exit 1; \
	fi
	@grep -q "All tests passed!" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
